// File: mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Memory side types: address and data words, read command and read data
////////////////////////////////////////////////////////////////////////////

package mem_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	// Word address, not byte address
	typedef logic [ADDR_WIDTH-1:0] addr_t;

	// Same width as a graph rank word
	typedef logic [DATA_WIDTH-1:0] data_t;

	typedef struct packed {
		logic  valid;
		addr_t address;
	} read_cmd_t;

	// Returned word, order not tied to command order
	typedef struct packed {
		logic  valid;
		data_t data;
	} read_data_t;

endpackage

// File: graph_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Graph types for the PageRank vertex compute unit
// Vertex job and rank write result
////////////////////////////////////////////////////////////////////////////

package graph_pkg;

	localparam int VERTEX_ID_WIDTH = 32;
	localparam int DEGREE_WIDTH    = 16;
	localparam int RANK_WIDTH      = 32;

	typedef logic [VERTEX_ID_WIDTH-1:0] vertex_id_t;

	// Out-degree, also used as the edge count
	typedef logic [DEGREE_WIDTH-1:0] degree_t;

	// Fixed-point rank contribution and sum
	typedef logic [RANK_WIDTH-1:0] rank_t;

	// Job from the host, one per vertex
	typedef struct packed {
		logic           valid;
		vertex_id_t     vertex_id;
		mem_pkg::addr_t edge_base;
		degree_t        out_degree;
	} vertex_job_t;

	// Result of one vertex
	typedef struct packed {
		logic       valid;
		vertex_id_t vertex_id;
		rank_t      rank_sum;
	} rank_write_t;

endpackage

// File: sync_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Show-ahead synchronous FIFO with occupancy count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	output logic             full,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             empty
);

	localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0]       mem [DEPTH];
	logic [PTR_WIDTH-1:0]   wr_ptr;
	logic [PTR_WIDTH-1:0]   rd_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic                   do_push;
	logic                   do_pop;

	// Wraps at DEPTH, so any depth works
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full     = (count == COUNT_WIDTH'(DEPTH));
	assign empty    = (count == '0);
	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	// Head word is always visible
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: vertex_control.sv
////////////////////////////////////////////////////////////////////////////
// Idle/busy vertex controller and completed vertex counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_control (
	input  logic                   clock,
	input  logic                   rstn,
	input  graph_pkg::vertex_job_t buffer_head,
	input  logic                   buffer_empty,
	output logic                   buffer_pop,
	output graph_pkg::vertex_job_t current_job,
	output logic                   start,
	input  logic                   done,
	output logic                   vertex_job_request,
	output graph_pkg::vertex_id_t  vertex_num_counter
);

	typedef enum logic {
		state_idle,
		state_busy
	} state_t;

	state_t state;

	// Take the next job only with no vertex in flight
	assign buffer_pop = (state == state_idle) && !buffer_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= state_idle;
			start <= 1'b0;
		end else begin
			// Start follows the pop, when current_job is loaded
			start <= buffer_pop;
			case (state)
				state_idle: begin
					if (buffer_pop) begin
						state <= state_busy;
					end
				end
				state_busy: begin
					if (done) begin
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (buffer_pop) begin
			current_job <= buffer_head;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Host request and vertex count
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_request <= 1'b0;
			vertex_num_counter <= '0;
		end else begin
			vertex_job_request <= buffer_empty;
			if (done) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
		end
	end

endmodule

// File: edge_read_issuer.sv
////////////////////////////////////////////////////////////////////////////
// Edge read issuer, one read command per edge of the current vertex
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_read_issuer (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::vertex_job_t current_job,
	input  logic                   cmd_full,
	output logic                   cmd_push,
	output mem_pkg::read_cmd_t     cmd
);

	import graph_pkg::*;
	import mem_pkg::*;

	addr_t   next_addr;
	degree_t remaining;

	// Stall on a full command FIFO, address holds until accepted
	assign cmd_push = (remaining != '0) && !cmd_full;
	assign cmd      = '{valid: cmd_push, address: next_addr};

	always_ff @(posedge clock) begin
		if (start) begin
			next_addr <= current_job.edge_base;
		end else if (cmd_push) begin
			next_addr <= next_addr + 1'b1;
		end
	end

	// Previous vertex has issued everything before its done,
	// so start never meets a non-zero count
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
		end else if (start) begin
			remaining <= current_job.out_degree;
		end else if (cmd_push) begin
			remaining <= remaining - 1'b1;
		end
	end

endmodule

// File: read_command_port.sv
////////////////////////////////////////////////////////////////////////////
// Read command buffer with bus request/grant and registered output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_command_port #(
	parameter int CMD_FIFO_DEPTH = 8
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               cmd_push,
	input  mem_pkg::read_cmd_t cmd,
	output logic               cmd_full,
	input  logic               read_command_bus_grant,
	output logic               read_command_bus_request,
	output mem_pkg::read_cmd_t read_command_out
);

	import mem_pkg::*;

	addr_t head_addr;
	logic  cmd_empty;
	logic  cmd_pop;

	// Grant alone does nothing
	assign cmd_pop = read_command_bus_request && read_command_bus_grant;

	sync_fifo #(
		.WIDTH($bits(addr_t)),
		.DEPTH(CMD_FIFO_DEPTH)
	) cmd_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (cmd_push),
		.data_in (cmd.address),
		.full    (cmd_full),
		.pop     (cmd_pop),
		.data_out(head_addr),
		.empty   (cmd_empty)
	);

	// Request drops for one cycle after each pop, so a raised
	// request always has a word behind it
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_bus_request <= 1'b0;
			read_command_out         <= '0;
		end else begin
			read_command_bus_request <= !cmd_empty && !cmd_pop;
			read_command_out         <= '{valid: cmd_pop, address: head_addr};
		end
	end

endmodule

// File: rank_accumulator.sv
////////////////////////////////////////////////////////////////////////////
// Rank accumulator, sums returned words and emits the vertex result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rank_accumulator (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  graph_pkg::vertex_job_t current_job,
	input  mem_pkg::read_data_t    read_data_in,
	output logic                   done,
	output graph_pkg::rank_write_t rank_write_out
);

	import graph_pkg::*;

	logic    active;
	rank_t   sum;
	degree_t received;
	logic    data_hit;
	rank_t   sum_next;
	degree_t received_next;
	logic    finish;

	// Words outside an active vertex are dropped
	assign data_hit      = active && read_data_in.valid;
	assign sum_next      = data_hit ? sum + rank_t'(read_data_in.data) : sum;
	assign received_next = data_hit ? received + 1'b1 : received;
	// Last word goes straight into the result
	assign finish        = active && (received_next == current_job.out_degree);

	always_ff @(posedge clock) begin
		if (start) begin
			sum      <= '0;
			received <= '0;
		end else begin
			sum      <= sum_next;
			received <= received_next;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			active         <= 1'b0;
			done           <= 1'b0;
			rank_write_out <= '0;
		end else begin
			done                 <= 1'b0;
			rank_write_out.valid <= 1'b0;
			if (start) begin
				if (current_job.out_degree == '0) begin
					// No edges, retire on the next edge
					done           <= 1'b1;
					rank_write_out <= '{valid: 1'b1, vertex_id: current_job.vertex_id,
						rank_sum: '0};
				end else begin
					active <= 1'b1;
				end
			end else if (finish) begin
				active         <= 1'b0;
				done           <= 1'b1;
				rank_write_out <= '{valid: 1'b1, vertex_id: current_job.vertex_id,
					rank_sum: sum_next};
			end
		end
	end

endmodule

// File: pr_compute_unit.sv
////////////////////////////////////////////////////////////////////////////
// PageRank vertex compute unit top level
// Input register, vertex buffer, control and datapath instances
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pr_compute_unit #(
	parameter int VERTEX_FIFO_DEPTH = 16,
	parameter int CMD_FIFO_DEPTH    = 8
) (
	input  logic                   clock,
	input  logic                   rstn,
	input  graph_pkg::vertex_job_t vertex_job,
	output logic                   vertex_job_request,
	input  logic                   read_command_bus_grant,
	output logic                   read_command_bus_request,
	output mem_pkg::read_cmd_t     read_command_out,
	input  mem_pkg::read_data_t    read_data_in,
	output graph_pkg::rank_write_t rank_write_out,
	output graph_pkg::vertex_id_t  vertex_num_counter
);

	import graph_pkg::*;
	import mem_pkg::*;

	vertex_job_t job_reg;
	vertex_job_t buffer_head;
	vertex_job_t current_job;
	logic        buffer_full;
	logic        buffer_empty;
	logic        buffer_pop;
	logic        start;
	logic        done;
	logic        cmd_push;
	logic        cmd_full;
	read_cmd_t   cmd;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_reg <= '0;
		end else begin
			job_reg <= vertex_job;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Vertex buffer
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(VERTEX_FIFO_DEPTH)
	) vertex_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_reg.valid && !buffer_full),
		.data_in (job_reg),
		.full    (buffer_full),
		.pop     (buffer_pop),
		.data_out(buffer_head),
		.empty   (buffer_empty)
	);

	vertex_control u_vertex_control (
		.clock             (clock),
		.rstn              (rstn),
		.buffer_head       (buffer_head),
		.buffer_empty      (buffer_empty),
		.buffer_pop        (buffer_pop),
		.current_job       (current_job),
		.start             (start),
		.done              (done),
		.vertex_job_request(vertex_job_request),
		.vertex_num_counter(vertex_num_counter)
	);

	////////////////////////////////////////////////////////////////////////////
	// Datapath, one vertex in flight
	////////////////////////////////////////////////////////////////////////////

	edge_read_issuer u_edge_read_issuer (
		.clock      (clock),
		.rstn       (rstn),
		.start      (start),
		.current_job(current_job),
		.cmd_full   (cmd_full),
		.cmd_push   (cmd_push),
		.cmd        (cmd)
	);

	read_command_port #(
		.CMD_FIFO_DEPTH(CMD_FIFO_DEPTH)
	) u_read_command_port (
		.clock                   (clock),
		.rstn                    (rstn),
		.cmd_push                (cmd_push),
		.cmd                     (cmd),
		.cmd_full                (cmd_full),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out)
	);

	rank_accumulator u_rank_accumulator (
		.clock         (clock),
		.rstn          (rstn),
		.start         (start),
		.current_job   (current_job),
		.read_data_in  (read_data_in),
		.done          (done),
		.rank_write_out(rank_write_out)
	);

endmodule

// File: pr_compute_unit_sva.sv
////////////////////////////////////////////////////////////////////////////
// Protocol assertions on the compute unit ports, bound to the top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pr_compute_unit_sva (
	input logic                   clock,
	input logic                   rstn,
	input logic                   vertex_job_request,
	input logic                   read_command_bus_grant,
	input logic                   read_command_bus_request,
	input mem_pkg::read_cmd_t     read_command_out,
	input graph_pkg::rank_write_t rank_write_out,
	input graph_pkg::vertex_id_t  vertex_num_counter
);

	// Control outputs read back as zero after a reset edge
	reset_values: assert property (@(posedge clock) !rstn |=> (!vertex_job_request
		&& !read_command_bus_request && !read_command_out.valid
		&& !rank_write_out.valid && vertex_num_counter == '0))
		else $error("control output not zero after reset");

	cmd_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		read_command_out.valid |-> $past(read_command_bus_request && read_command_bus_grant))
		else $error("read command without request and grant");

	grant_gives_cmd: assert property (@(posedge clock) disable iff (!rstn)
		(read_command_bus_request && read_command_bus_grant) |=> read_command_out.valid)
		else $error("request and grant gave no read command");

	////////////////////////////////////////////////////////////////////////////
	// Vertex counter follows each result by one cycle
	////////////////////////////////////////////////////////////////////////////

	counter_step: assert property (@(posedge clock) disable iff (!rstn)
		rank_write_out.valid |=> vertex_num_counter == $past(vertex_num_counter) + 32'd1)
		else $error("vertex counter did not step after a result");

	counter_hold: assert property (@(posedge clock) disable iff (!rstn)
		!rank_write_out.valid |=> vertex_num_counter == $past(vertex_num_counter))
		else $error("vertex counter moved without a result");

endmodule

bind pr_compute_unit pr_compute_unit_sva u_sva (
	.clock                   (clock),
	.rstn                    (rstn),
	.vertex_job_request      (vertex_job_request),
	.read_command_bus_grant  (read_command_bus_grant),
	.read_command_bus_request(read_command_bus_request),
	.read_command_out        (read_command_out),
	.rank_write_out          (rank_write_out),
	.vertex_num_counter      (vertex_num_counter)
);

// File: tb_pr_compute_unit.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the PageRank vertex compute unit
// Clock, reset, LCG stimulus, memory model and scoreboard
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_pr_compute_unit;

	import graph_pkg::*;
	import mem_pkg::*;

	localparam int VERTEX_FIFO_DEPTH = 16;
	localparam int CMD_FIFO_DEPTH    = 4;
	localparam int TIMEOUT_CYCLES    = 5000;

	logic        clock;
	logic        rstn;
	vertex_job_t vertex_job;
	logic        vertex_job_request;
	logic        read_command_bus_grant;
	logic        read_command_bus_request;
	read_cmd_t   read_command_out;
	read_data_t  read_data_in;
	rank_write_t rank_write_out;
	vertex_id_t  vertex_num_counter;

	// Scoreboard and memory model state
	logic [31:0] lcg_state;
	vertex_job_t to_send[$];
	addr_t       exp_addr[$];
	vertex_id_t  exp_ids[$];
	rank_t       exp_sums[$];
	addr_t       pending[$];
	int          jobs_sent;
	int          results_seen;
	int          gap_left;
	bit          long_gaps;

	pr_compute_unit #(
		.VERTEX_FIFO_DEPTH(VERTEX_FIFO_DEPTH),
		.CMD_FIFO_DEPTH   (CMD_FIFO_DEPTH)
	) uut (
		.clock                   (clock),
		.rstn                    (rstn),
		.vertex_job              (vertex_job),
		.vertex_job_request      (vertex_job_request),
		.read_command_bus_grant  (read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out),
		.read_data_in            (read_data_in),
		.rank_write_out          (rank_write_out),
		.vertex_num_counter      (vertex_num_counter)
	);

	always #10 clock = ~clock;

	function automatic logic [31:0] next_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned next_random(input int unsigned range);
		return (next_word() >> 8) % range;
	endfunction

	// Memory word at address a is a * 3 + 7
	function automatic rank_t mem_value(input addr_t a);
		return rank_t'(a * 32'd3 + 32'd7);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Failure at time %0t: %s", $time, what);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (expected == actual) else report_mismatch(name, expected, actual);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Per-cycle output sampling and input driving
	////////////////////////////////////////////////////////////////////////////

	task automatic step();
		addr_t       want_addr;
		int unsigned idx;
		@(negedge clock);
		if (read_command_out.valid) begin
			assert (exp_addr.size() > 0) else report_failure("read command nobody expected");
			want_addr = exp_addr.pop_front();
			check_value("read_command_out.address", want_addr, read_command_out.address);
			pending.push_back(read_command_out.address);
		end
		if (rank_write_out.valid) begin
			assert (exp_ids.size() > 0) else report_failure("rank write nobody expected");
			check_value("rank_write_out.vertex_id", exp_ids.pop_front(), rank_write_out.vertex_id);
			check_value("rank_write_out.rank_sum", exp_sums.pop_front(), rank_write_out.rank_sum);
			results_seen++;
		end
		// Memory returns one randomly picked pending word
		read_data_in = '0;
		if (pending.size() > 0 && next_random(2) == 0) begin
			idx = next_random(pending.size());
			read_data_in = '{valid: 1'b1, data: mem_value(pending[idx])};
			pending.delete(idx);
		end
		if (gap_left > 0) begin
			read_command_bus_grant = 1'b0;
			gap_left--;
		end else begin
			read_command_bus_grant = 1'b1;
			if (long_gaps && next_random(2) == 0) begin
				gap_left = 8 + next_random(20);
			end else if (!long_gaps) begin
				gap_left = next_random(3);
			end
		end
		if (to_send.size() > 0) begin
			vertex_job = to_send.pop_front();
		end else begin
			vertex_job = '0;
		end
	endtask

	task automatic wait_request();
		int waited;
		bit seen;
		waited = 0;
		seen = 1'b0;
		while (!seen && waited < TIMEOUT_CYCLES) begin
			step();
			seen = vertex_job_request;
			waited++;
		end
		if (!seen) begin
			report_failure("timeout waiting for vertex_job_request");
		end
	endtask

	task automatic wait_results(input int target);
		int waited;
		waited = 0;
		while (results_seen < target && waited < TIMEOUT_CYCLES) begin
			step();
			waited++;
		end
		if (results_seen < target) begin
			report_failure("timeout waiting for rank write results");
		end
	endtask

	// Queue one job and its expected addresses and sum
	task automatic queue_job(input degree_t degree);
		addr_t       base;
		vertex_id_t  id;
		rank_t       sum;
		vertex_job_t job;
		base = next_word();
		id = 32'h1000 + vertex_id_t'(jobs_sent + to_send.size());
		sum = '0;
		for (int k = 0; k < int'(degree); k++) begin
			exp_addr.push_back(base + addr_t'(k));
			sum = sum + mem_value(base + addr_t'(k));
		end
		exp_ids.push_back(id);
		exp_sums.push_back(sum);
		job = '{valid: 1'b1, vertex_id: id, edge_base: base, out_degree: degree};
		to_send.push_back(job);
	endtask

	task automatic send_batch();
		int count;
		count = to_send.size();
		jobs_sent += count;
		wait_results(jobs_sent);
	endtask

	initial begin
		clock = 1'b0;
		rstn = 1'b0;
		vertex_job = '0;
		read_command_bus_grant = 1'b0;
		read_data_in = '0;
		lcg_state = 32'h3c4;
		jobs_sent = 0;
		results_seen = 0;
		gap_left = 0;
		long_gaps = 1'b0;
		repeat (5) @(negedge clock);
		rstn = 1'b1;
		check_value("vertex_job_request", 32'd0, 32'(vertex_job_request));
		check_value("read_command_bus_request", 32'd0, 32'(read_command_bus_request));
		check_value("read_command_out.valid", 32'd0, 32'(read_command_out.valid));
		check_value("rank_write_out.valid", 32'd0, 32'(rank_write_out.valid));
		check_value("vertex_num_counter", 32'd0, vertex_num_counter);

		// Degree-zero vertices around a short one
		wait_request();
		queue_job(16'd0);
		queue_job(16'd3);
		queue_job(16'd0);
		send_batch();

		// Full vertex buffer of random jobs
		wait_request();
		for (int i = 0; i < VERTEX_FIFO_DEPTH; i++) begin
			queue_job(degree_t'(next_random(7)));
		end
		send_batch();

		// Long grant gaps fill the command FIFO
		long_gaps = 1'b1;
		wait_request();
		queue_job(16'd6);
		queue_job(16'd6);
		for (int i = 0; i < 6; i++) begin
			queue_job(degree_t'(next_random(7)));
		end
		send_batch();
		long_gaps = 1'b0;

		wait_request();
		for (int i = 0; i < VERTEX_FIFO_DEPTH; i++) begin
			queue_job(degree_t'(next_random(7)));
		end
		send_batch();

		// Counter moves one cycle after the last result
		step();
		check_value("vertex_num_counter", jobs_sent, vertex_num_counter);
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: sim.f
mem_pkg.sv
graph_pkg.sv
sync_fifo.sv
vertex_control.sv
edge_read_issuer.sv
read_command_port.sv
rank_accumulator.sv
pr_compute_unit.sv
pr_compute_unit_sva.sv
tb_pr_compute_unit.sv

// File: run.sh
#!/bin/sh
# Build and run the compute unit testbench with Verilator, then scan the log
verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module tb_pr_compute_unit -f sim.f -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
